//--- logic/xbar_settings.svh
`ifndef XBAR_SETTINGS_SVH
`define XBAR_SETTINGS_SVH

////////////////////////////////////////////////////////////
// Master population
////////////////////////////////////////////////////////////

`define XBAR_N_CH0      4   // Cores, high priority
`define XBAR_N_CH1      1   // DMA ports, low priority
`define XBAR_N_MASTERS  (`XBAR_N_CH0 + `XBAR_N_CH1)

////////////////////////////////////////////////////////////
// Memory geometry
////////////////////////////////////////////////////////////

`define XBAR_N_BANKS    4   // Word interleaved
`define XBAR_DATA_WIDTH 32
`define XBAR_ADDR_WIDTH 5   // 32 rows per bank

// Bank index width, kept at one bit minimum for a single bank
`define XBAR_BANK_BITS  ((`XBAR_N_BANKS > 1) ? $clog2(`XBAR_N_BANKS) : 1)

`endif

//--- logic/xbar_pkg.sv
`include "xbar_settings.svh"

package xbar_pkg;

    // Master index over both channels, ch1 sits above ch0
    typedef logic [(`XBAR_N_MASTERS > 1 ? $clog2(`XBAR_N_MASTERS) : 1)-1:0] master_id_t;

    // Destination bank index
    typedef logic [`XBAR_BANK_BITS-1:0] bank_id_t;

    // One bit per master
    // Bits [N_CH0-1:0] are channel 0, the rest channel 1
    typedef logic [`XBAR_N_MASTERS-1:0] master_vec_t;

    // One bit per bank
    typedef logic [`XBAR_N_BANKS-1:0] bank_vec_t;

endpackage

//--- logic/scm_pkg.sv
`include "xbar_settings.svh"

package scm_pkg;

    // Row inside one bank
    typedef logic [`XBAR_ADDR_WIDTH-1:0] row_addr_t;

    // Stored word
    typedef logic [`XBAR_DATA_WIDTH-1:0] word_t;

    // One enable per byte lane
    typedef logic [`XBAR_DATA_WIDTH/8-1:0] byte_en_t;

endpackage

//--- logic/bank_wr_if.sv
`timescale 1ns/1ns

interface bank_wr_if;
    import scm_pkg::*;

    logic      wr_req;   // Write this cycle
    row_addr_t wr_addr;  // Target row
    word_t     wr_data;  // Write payload
    byte_en_t  wr_be;    // Byte lanes to update

    // Winner of the bank arbitration drives everything
    modport arbiter
    (
        output wr_req, wr_addr, wr_data, wr_be
    );

    // Bank samples at rising clk when wr_req is high
    modport bank
    (
        input wr_req, wr_addr, wr_data, wr_be
    );

endinterface

//--- logic/route_decoder.sv
`timescale 1ns/1ns
`include "xbar_settings.svh"

module route_decoder
(
    input  logic                data_req_i,   // Master request
    input  xbar_pkg::bank_id_t  data_dest_i,  // Target bank
    output xbar_pkg::bank_vec_t bank_req_o,   // One-hot request toward the banks
    input  xbar_pkg::bank_vec_t bank_gnt_i,   // Grants coming back from every bank
    output logic                data_gnt_o    // Grant seen by the master
);
    import xbar_pkg::*;

    bank_id_t route;  // Effective bank index

    // A single bank needs no routing information
    assign route = (`XBAR_N_BANKS == 1) ? '0 : data_dest_i;

    ////////////////////////////////////////////////////////////
    // Request fan-out
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        bank_req_o = '0;
        if (data_req_i)
        begin
            bank_req_o = bank_vec_t'(1) << route;  // Exactly one bank asked
        end
    end

    ////////////////////////////////////////////////////////////
    // Grant return
    ////////////////////////////////////////////////////////////

    // Only the addressed bank can have granted this master
    assign data_gnt_o = bank_gnt_i[route];

endmodule

//--- logic/bank_arbiter.sv
`timescale 1ns/1ns
`include "xbar_settings.svh"

module bank_arbiter
(
    input  logic                                     clk,
    input  logic                                     reset_i,
    input  xbar_pkg::master_vec_t                    req_i,         // Column of requests
    output xbar_pkg::master_vec_t                    gnt_o,         // Column of grants
    input  scm_pkg::row_addr_t [`XBAR_N_MASTERS-1:0] data_add_i,
    input  scm_pkg::word_t     [`XBAR_N_MASTERS-1:0] data_wdata_i,
    input  scm_pkg::byte_en_t  [`XBAR_N_MASTERS-1:0] data_be_i,
    bank_wr_if.arbiter                               wr             // Toward the bank
);
    import xbar_pkg::*;

    master_id_t ch0_ptr;   // Highest priority core next round
    master_id_t ch1_ptr;   // Highest priority DMA next round
    master_id_t ch0_win;
    master_id_t ch1_win;
    master_id_t gnt_sel;   // Final winner
    logic       ch0_any;
    logic       ch1_any;

    // First requester at or after ptr, wrapping inside [base, base+count)
    function automatic master_id_t rr_pick(input master_vec_t req, input master_id_t ptr,
                                           input int base, input int count);
        int offs;
        int idx;
        master_id_t pick;
        pick = ptr;
        for (int i = `XBAR_N_MASTERS - 1; i >= 0; i--)  // Downward, lowest offset wins
        begin
            if (i < count)
            begin
                offs = int'(ptr) - base + i;
                if (offs >= count)
                    offs = offs - count;
                idx = base + offs;
                if (req[idx])
                    pick = master_id_t'(idx);
            end
        end
        return pick;
    endfunction

    // Master after the winner, wrapping inside its channel
    function automatic master_id_t rr_next(input master_id_t win, input int base,
                                           input int count);
        int nxt;
        nxt = int'(win) + 1;
        if (nxt >= base + count)
            nxt = base;
        return master_id_t'(nxt);
    endfunction

    ////////////////////////////////////////////////////////////
    // Winner selection
    ////////////////////////////////////////////////////////////

    assign ch0_any = |req_i[`XBAR_N_CH0-1:0];
    assign ch1_any = |(req_i >> `XBAR_N_CH0);  // Empty when there is no DMA channel
    assign ch0_win = rr_pick(req_i, ch0_ptr, 0, `XBAR_N_CH0);
    assign ch1_win = rr_pick(req_i, ch1_ptr, `XBAR_N_CH0, `XBAR_N_CH1);

    // Cores always beat DMA
    assign gnt_sel = ch0_any ? ch0_win : ch1_win;

    assign gnt_o = (ch0_any || ch1_any) ? (master_vec_t'(1) << gnt_sel) : '0;

    // Winner payload steered straight onto the bank port
    assign wr.wr_req  = ch0_any || ch1_any;  // Bank never stalls
    assign wr.wr_addr = data_add_i[gnt_sel];
    assign wr.wr_data = data_wdata_i[gnt_sel];
    assign wr.wr_be   = data_be_i[gnt_sel];

    ////////////////////////////////////////////////////////////
    // Round-robin pointers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset_i)
        begin
            ch0_ptr <= '0;                             // Lowest core
            ch1_ptr <= master_id_t'(`XBAR_N_CH0);      // Lowest DMA port
        end
        else if (ch0_any)
        begin
            ch0_ptr <= rr_next(ch0_win, 0, `XBAR_N_CH0);
        end
        else if (ch1_any)
        begin
            // DMA pointer only moves when it actually won
            ch1_ptr <= rr_next(ch1_win, `XBAR_N_CH0, `XBAR_N_CH1);
        end
    end

endmodule

//--- logic/scm_bank.sv
`timescale 1ns/1ns
`include "xbar_settings.svh"

module scm_bank
(
    input  logic               clk,
    input  logic               reset_i,
    bank_wr_if.bank            wr,         // Arbitrated write
    input  scm_pkg::row_addr_t rd_addr_i,  // Inspection read row
    output scm_pkg::word_t     rd_data_o   // One cycle after rd_addr_i
);
    import scm_pkg::*;

    // Storage array, contents undefined after reset
    word_t mem [2**`XBAR_ADDR_WIDTH];

    ////////////////////////////////////////////////////////////
    // Write port
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (wr.wr_req)
        begin
            for (int b = 0; b < $bits(byte_en_t); b++)
            begin
                if (wr.wr_be[b])  // Untouched lanes keep old contents
                begin
                    mem[wr.wr_addr][8*b +: 8] <= wr.wr_data[8*b +: 8];
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Read port
    ////////////////////////////////////////////////////////////

    // Old data when reading a row written in the same cycle
    always_ff @(posedge clk)
    begin
        if (reset_i)
        begin
            rd_data_o <= '0;
        end
        else
        begin
            rd_data_o <= mem[rd_addr_i];
        end
    end

endmodule

//--- logic/xbar_scm_top.sv
`timescale 1ns/1ns
`include "xbar_settings.svh"

module xbar_scm_top
(
    input  logic                                     clk,
    input  logic                                     reset_i,
    input  xbar_pkg::master_vec_t                    data_req_i,
    input  xbar_pkg::bank_id_t [`XBAR_N_MASTERS-1:0] data_dest_i,   // Bank per master
    input  scm_pkg::row_addr_t [`XBAR_N_MASTERS-1:0] data_add_i,    // Row per master
    input  scm_pkg::word_t     [`XBAR_N_MASTERS-1:0] data_wdata_i,
    input  scm_pkg::byte_en_t  [`XBAR_N_MASTERS-1:0] data_be_i,
    output xbar_pkg::master_vec_t                    data_gnt_o,    // Same-cycle grant
    input  xbar_pkg::bank_id_t                       rd_bank_i,
    input  scm_pkg::row_addr_t                       rd_addr_i,
    output scm_pkg::word_t                           rd_data_o
);
    import xbar_pkg::*;
    import scm_pkg::*;

    bank_vec_t   [`XBAR_N_MASTERS-1:0] req_row;     // One bit per bank for each master
    bank_vec_t   [`XBAR_N_MASTERS-1:0] gnt_row;
    master_vec_t [`XBAR_N_BANKS-1:0]   req_col;     // One bit per master for each bank
    master_vec_t [`XBAR_N_BANKS-1:0]   gnt_col;
    word_t       [`XBAR_N_BANKS-1:0]   bank_rdata;
    bank_id_t                          rd_bank_q;   // Aligned with the bank read register

    ////////////////////////////////////////////////////////////
    // Decode side
    ////////////////////////////////////////////////////////////

    for (genvar m = 0; m < `XBAR_N_MASTERS; m++)
    begin : g_decode
        route_decoder u_route_decoder
        (
            .data_req_i  ( data_req_i[m]  ),
            .data_dest_i ( data_dest_i[m] ),
            .bank_req_o  ( req_row[m]     ),
            .bank_gnt_i  ( gnt_row[m]     ),
            .data_gnt_o  ( data_gnt_o[m]  )
        );
    end

    // Requests regrouped by bank
    always_comb
    begin
        for (int b = 0; b < `XBAR_N_BANKS; b++)
        begin
            for (int m = 0; m < `XBAR_N_MASTERS; m++)
            begin
                req_col[b][m] = req_row[m][b];
            end
        end
    end

    // Grants regrouped by master
    always_comb
    begin
        for (int m = 0; m < `XBAR_N_MASTERS; m++)
        begin
            for (int b = 0; b < `XBAR_N_BANKS; b++)
            begin
                gnt_row[m][b] = gnt_col[b][m];
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Per-bank arbitration and storage
    ////////////////////////////////////////////////////////////

    for (genvar b = 0; b < `XBAR_N_BANKS; b++)
    begin : g_bank
        bank_wr_if u_wr ();

        bank_arbiter u_bank_arbiter
        (
            .clk          ( clk          ),
            .reset_i      ( reset_i      ),
            .req_i        ( req_col[b]   ),
            .gnt_o        ( gnt_col[b]   ),
            .data_add_i   ( data_add_i   ),  // Full set as the winner is picked inside
            .data_wdata_i ( data_wdata_i ),
            .data_be_i    ( data_be_i    ),
            .wr           ( u_wr         )
        );

        scm_bank u_scm_bank
        (
            .clk       ( clk           ),
            .reset_i   ( reset_i       ),
            .wr        ( u_wr          ),
            .rd_addr_i ( rd_addr_i     ),  // Broadcast row
            .rd_data_o ( bank_rdata[b] )
        );
    end

    // Inspection read path
    always_ff @(posedge clk)
    begin
        if (reset_i)
        begin
            rd_bank_q <= '0;
        end
        else
        begin
            rd_bank_q <= rd_bank_i;
        end
    end

    assign rd_data_o = bank_rdata[rd_bank_q];  // Registered word of the chosen bank

endmodule

//--- bench/tb_xbar_scm.sv
`timescale 1ns/1ns
`include "xbar_settings.svh"

module tb_xbar_scm;
    import xbar_pkg::*;
    import scm_pkg::*;

    logic                                clk = 1'b0;
    logic                                reset_i;
    master_vec_t                         data_req_i;
    bank_id_t  [`XBAR_N_MASTERS-1:0]     data_dest_i;
    row_addr_t [`XBAR_N_MASTERS-1:0]     data_add_i;
    word_t     [`XBAR_N_MASTERS-1:0]     data_wdata_i;
    byte_en_t  [`XBAR_N_MASTERS-1:0]     data_be_i;
    master_vec_t                         data_gnt_o;
    bank_id_t                            rd_bank_i;
    row_addr_t                           rd_addr_i;
    word_t                               rd_data_o;

    word_t mem_model [`XBAR_N_BANKS][2**`XBAR_ADDR_WIDTH];  // Expected contents
    int    ptr0 [`XBAR_N_BANKS];    // Core pointer per bank
    int    ptr1 [`XBAR_N_BANKS];    // DMA pointer as offset inside channel 1
    logic  rd_chk, rd_pend;         // Read issued / read result due
    word_t rd_exp;
    int    rd_b, rd_r;
    int    errors, err_base, n_pass, n_fail;
    logic  timeout_hit = 1'b0;
    int    seed = 64;

    xbar_scm_top u_xbar_scm_top (.*);

    always #5 clk = ~clk;

    task automatic flag_error(input string msg);
        $display("** Error at %0t ns: %s", $time, msg);
        errors++;
    endtask

    ////////////////////////////////////////////////////////////
    // Reference model and checks
    ////////////////////////////////////////////////////////////

    assert property (@(posedge clk) disable iff (reset_i) (data_gnt_o & ~data_req_i) == '0)
        else flag_error("grant raised without a request");

    always @(posedge clk)
    begin
        master_vec_t exp_gnt;
        int w0, w1, idx, n_gnt;
        if (reset_i)
        begin
            ptr0    = '{default: 0};
            ptr1    = '{default: 0};
            rd_pend = 1'b0;
        end
        else
        begin
            if (rd_pend)  // Word read one edge ago
                assert (rd_data_o === rd_exp) else flag_error($sformatf(
                    "bank %0d row %0d read %h, expected %h", rd_b, rd_r, rd_data_o, rd_exp));
            rd_pend = rd_chk;
            rd_b    = rd_bank_i;
            rd_r    = rd_addr_i;
            rd_exp  = mem_model[rd_bank_i][rd_addr_i];  // Before this edge's writes
            exp_gnt = '0;
            for (int b = 0; b < `XBAR_N_BANKS; b++)
            begin
                w0    = -1;
                w1    = -1;
                n_gnt = 0;
                for (int k = `XBAR_N_CH0 - 1; k >= 0; k--)  // Nearest to pointer wins
                begin
                    idx = (ptr0[b] + k) % `XBAR_N_CH0;
                    if (data_req_i[idx] && data_dest_i[idx] == b)
                        w0 = idx;
                end
                for (int k = `XBAR_N_CH1 - 1; k >= 0; k--)
                begin
                    idx = `XBAR_N_CH0 + (ptr1[b] + k) % `XBAR_N_CH1;
                    if (data_req_i[idx] && data_dest_i[idx] == b)
                        w1 = idx;
                end
                if (w0 >= 0)
                begin
                    exp_gnt[w0] = 1'b1;
                    ptr0[b]     = (w0 + 1) % `XBAR_N_CH0;
                end
                else if (w1 >= 0)
                begin
                    exp_gnt[w1] = 1'b1;
                    ptr1[b]     = (w1 - `XBAR_N_CH0 + 1) % `XBAR_N_CH1;
                end
                for (int m = 0; m < `XBAR_N_MASTERS; m++)
                    n_gnt += (data_gnt_o[m] && data_dest_i[m] == b);
                assert (n_gnt <= 1) else flag_error($sformatf("bank %0d granted %0d", b, n_gnt));
            end
            assert (data_gnt_o === exp_gnt) else flag_error($sformatf(
                "grant %b, expected %b", data_gnt_o, exp_gnt));
            for (int m = 0; m < `XBAR_N_MASTERS; m++)  // Predicted winners land at this edge
                for (int k = 0; k < $bits(byte_en_t); k++)
                    if (exp_gnt[m] && data_be_i[m][k])
                        mem_model[data_dest_i[m]][data_add_i[m]][8*k +: 8] =
                            data_wdata_i[m][8*k +: 8];
        end
    end

    ////////////////////////////////////////////////////////////
    // Stimulus tasks entered on a falling edge
    ////////////////////////////////////////////////////////////

    task automatic drive_req(input int m, input int b, input int row, input word_t d,
                             input byte_en_t be);
        data_req_i[m]   = 1'b1;
        data_dest_i[m]  = bank_id_t'(b);
        data_add_i[m]   = row_addr_t'(row);
        data_wdata_i[m] = d;
        data_be_i[m]    = be;
    endtask

    task automatic wait_grant(input int m, output int waited);
        waited = 0;
        @(posedge clk);
        while (!data_gnt_o[m] && waited <= 64)
        begin
            waited++;
            @(posedge clk);
        end
        if (!data_gnt_o[m])
        begin
            $display("Timeout: master %0d never received a grant", m);
            timeout_hit = 1'b1;
        end
    endtask

    task automatic write_word(input int m, input int b, input int row, input word_t d,
                              input byte_en_t be);
        int waited;
        drive_req(m, b, row, d, be);
        wait_grant(m, waited);
        @(negedge clk);
        data_req_i[m] = 1'b0;
    endtask

    task automatic read_word(input int b, input int row);
        rd_bank_i = bank_id_t'(b);
        rd_addr_i = row_addr_t'(row);
        rd_chk    = 1'b1;
        @(negedge clk);
        rd_chk    = 1'b0;
    endtask

    task automatic end_test(input string name);
        @(posedge clk);
        @(negedge clk);  // Last read check lands here
        if (errors == err_base)
            n_pass++;
        else
            n_fail++;
        $display("Test %s %s", name, (errors == err_base) ? "passed" : "failed");
        err_base = errors;
    endtask

    initial
    begin
        wait (timeout_hit);
        $display("SOME TESTS FAILED");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////

    initial
    begin
        int w;
        int cnt [`XBAR_N_CH0];
        int stall [`XBAR_N_MASTERS];
        master_vec_t got;
        reset_i      = 1'b1;
        data_req_i   = '0;
        data_dest_i  = '0;
        data_add_i   = '0;
        data_wdata_i = '0;
        data_be_i    = '0;
        rd_bank_i    = '0;
        rd_addr_i    = '0;
        rd_chk       = 1'b0;
        {errors, err_base, n_pass, n_fail} = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;

        for (int b = 0; b < `XBAR_N_BANKS; b++)  // Fills every word before any read
            for (int r = 0; r < 2**`XBAR_ADDR_WIDTH; r++)
                write_word((b + r) % `XBAR_N_MASTERS, b, r, $random(seed), '1);
        for (int b = 0; b < `XBAR_N_BANKS; b++)
            for (int r = 0; r < 2**`XBAR_ADDR_WIDTH; r++)
                read_word(b, r);
        end_test("single writes");

        write_word(1, 3, 7, 32'h1122_3344, 4'b1111);
        write_word(2, 3, 7, 32'hAABB_CCDD, 4'b0101);
        write_word(4, 3, 7, 32'h5566_7788, 4'b1000);
        read_word(3, 7);
        end_test("byte enables");

        drive_req(4, 2, 0, 32'hD0A0_0004, '1);  // DMA and core on one bank
        drive_req(0, 2, 1, 32'hC0E0_0000, '1);
        wait_grant(0, w);
        @(negedge clk);
        data_req_i[0] = 1'b0;
        wait_grant(4, w);
        assert (w == 0) else flag_error("channel 1 not granted right after channel 0 left");
        @(negedge clk);
        data_req_i[4] = 1'b0;
        read_word(2, 0);
        read_word(2, 1);
        end_test("channel priority");

        cnt = '{default: 0};
        for (int m = 0; m < `XBAR_N_CH0; m++)
            drive_req(m, 1, m, 32'hC0DE_0000 + m, '1);
        repeat (16)
        begin
            @(posedge clk);
            for (int m = 0; m < `XBAR_N_CH0; m++)
                cnt[m] += data_gnt_o[m];
        end
        @(negedge clk);
        data_req_i = '0;
        for (int m = 0; m < `XBAR_N_CH0; m++)
            assert (cnt[m] == 4) else flag_error($sformatf("core %0d got %0d grants", m, cnt[m]));
        end_test("round robin");

        for (int m = 0; m < `XBAR_N_BANKS; m++)
            drive_req(m, m, 20 + m, 32'hBA00_0000 + m, '1);
        @(posedge clk);
        assert (data_gnt_o[`XBAR_N_BANKS-1:0] == '1)
            else flag_error("parallel banks not all granted");
        @(negedge clk);
        data_req_i = '0;
        for (int b = 0; b < `XBAR_N_BANKS; b++)
            read_word(b, 20 + b);
        end_test("parallel banks");

        got   = '0;
        stall = '{default: 0};
        repeat (300)
        begin
            @(negedge clk);
            for (int m = 0; m < `XBAR_N_MASTERS; m++)
            begin
                if (got[m])
                    data_req_i[m] = 1'b0;
                if (!data_req_i[m] && $random(seed) % 2 != 0)  // Hold until granted
                    drive_req(m, $random(seed), $random(seed), $random(seed),
                              byte_en_t'($random(seed)));
            end
            @(posedge clk);
            got = data_gnt_o;
            for (int m = 0; m < `XBAR_N_MASTERS; m++)
            begin
                stall[m] = (data_req_i[m] && !got[m]) ? stall[m] + 1 : 0;
                if (stall[m] > 64)
                begin
                    $display("Timeout: master %0d starved in random traffic", m);
                    timeout_hit = 1'b1;
                end
            end
        end
        @(negedge clk);
        data_req_i = '0;
        for (int b = 0; b < `XBAR_N_BANKS; b++)
            for (int r = 0; r < 2**`XBAR_ADDR_WIDTH; r++)
                read_word(b, r);
        end_test("random traffic");

        $display("Tests passed: %0d, failed: %0d", n_pass, n_fail);
        if (n_fail == 0 && errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

//--- sources.f
+incdir+logic
logic/xbar_pkg.sv
logic/scm_pkg.sv
logic/bank_wr_if.sv
logic/route_decoder.sv
logic/bank_arbiter.sv
logic/scm_bank.sv
logic/xbar_scm_top.sv
bench/tb_xbar_scm.sv

//--- Bender.yml
package:
  name: xbar_scm

sources:
  - include_dirs:
      - logic
    files:
      - logic/xbar_pkg.sv
      - logic/scm_pkg.sv
      - logic/bank_wr_if.sv
      - logic/route_decoder.sv
      - logic/bank_arbiter.sv
      - logic/scm_bank.sv
      - logic/xbar_scm_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - bench/tb_xbar_scm.sv
